// File: dv/rv_checker.sv
// In-order reference model of the RV32I slice, compared at each retire
// Samples on the falling edge, away from the DUT's active edge
`timescale 1ns/1ps

module rv_checker (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  rv_pkg::xlen_t   in_pc,
    input  rv_pkg::instr_t  in_instr,
    input  logic [7:0]      test_id,
    input  rv_pkg::retire_t retire,
    output int              error_count,
    output int              check_count,
    output int              pending
);

    typedef struct packed {
        rv_pkg::retire_t exp;
        logic [31:0]     cycle;
        logic [7:0]      test_id;
    } expect_t;

    expect_t       exp_q [$];
    rv_pkg::xlen_t shadow [32];
    logic [31:0]   cycle;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1: return "class_decode";
            8'd2: return "alu";
            8'd3: return "upper_imm";
            8'd4: return "dependency";
            8'd5: return "x0";
            8'd6: return "random";
            default: return "unknown";
        endcase
    endfunction

    // alt selects sub for funct3 000 and sra for funct3 101
    function automatic rv_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Applies one instruction to the shadow registers in program order
    function automatic rv_pkg::retire_t ref_retire(input rv_pkg::xlen_t pc,
                                                   input rv_pkg::instr_t instr);
        rv_pkg::retire_t r;
        rv_pkg::xlen_t   rs1v;
        rv_pkg::xlen_t   imm_u;
        logic [2:0]      f3;
        logic            exec;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = instr[11:7];
        rs1v    = shadow[instr[19:15]];
        imm_u   = {instr[31:12], 12'h000};
        f3      = instr[14:12];
        exec    = 1'b1;
        case (instr[6:0])
            7'b0110111: begin
                r.iclass = rv_pkg::CL_LUI;
                r.result = imm_u;
            end
            7'b0010111: begin
                r.iclass = rv_pkg::CL_AUIPC;
                r.result = pc + imm_u;
            end
            7'b0010011: begin
                r.iclass = rv_pkg::CL_OPIMM;
                r.result = alu_ref(f3, (f3 == 3'b101) && instr[30], rs1v,
                                   {{20{instr[31]}}, instr[31:20]});
            end
            7'b0110011: begin
                r.iclass = rv_pkg::CL_OP;
                r.result = alu_ref(f3, instr[30], rs1v, shadow[instr[24:20]]);
            end
            default: begin
                exec = 1'b0;
                case (instr[6:0])
                    7'b1101111: r.iclass = rv_pkg::CL_JAL;
                    7'b1100111: r.iclass = rv_pkg::CL_JALR;
                    7'b1100011: r.iclass = rv_pkg::CL_BRANCH;
                    7'b0000011: r.iclass = rv_pkg::CL_LOAD;
                    7'b0100011: r.iclass = rv_pkg::CL_STORE;
                    7'b1110011: r.iclass = rv_pkg::CL_SYSTEM;
                    7'b0001111: r.iclass = rv_pkg::CL_FENCE;
                    default: begin
                        r.iclass  = rv_pkg::CL_ILLEGAL;
                        r.illegal = 1'b1;
                    end
                endcase
            end
        endcase
        if (exec && (r.rd != 5'd0)) begin
            r.wrote      = 1'b1;
            shadow[r.rd] = r.result;
        end
        return r;
    endfunction

    task automatic check_field(input string tname, input string field,
                               input rv_pkg::xlen_t pc, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            error_count++;
            $display("** Error [%s] pc %08h %s: expected %0h, actual %0h",
                     tname, pc, field, exp, act);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
        cycle       = '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
    end

    always @(negedge aclk) begin
        expect_t e;
        string   tname;
        if (arst_n) begin
            if (retire.valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected retire at pc %08h with nothing outstanding",
                             retire.pc);
                end else begin
                    e     = exp_q.pop_front();
                    tname = test_name(e.test_id);
                    check_count++;
                    check_field(tname, "latency", e.exp.pc, e.cycle + 32'd3, cycle);
                    check_field(tname, "pc", e.exp.pc, e.exp.pc, retire.pc);
                    check_field(tname, "class", e.exp.pc, e.exp.iclass, retire.iclass);
                    check_field(tname, "rd", e.exp.pc, e.exp.rd, retire.rd);
                    check_field(tname, "result", e.exp.pc, e.exp.result, retire.result);
                    check_field(tname, "wrote", e.exp.pc, e.exp.wrote, retire.wrote);
                    check_field(tname, "illegal", e.exp.pc, e.exp.illegal, retire.illegal);
                end
            end
            if (in_valid) begin
                e.exp     = ref_retire(in_pc, in_instr);
                e.cycle   = cycle;
                e.test_id = test_id;
                exp_q.push_back(e);
            end
            pending = exp_q.size();
            cycle   = cycle + 32'd1;
        end
    end

endmodule

// File: dv/rv_core_asserts.sv
// Bound assertions on rv_core for latency, reset state and the x0 write rule
// Latency checks assume the pipeline never stalls
`timescale 1ns/1ps

module rv_core_asserts (
    input logic              aclk,
    input logic              arst_n,
    input logic              in_valid,
    input rv_pkg::dec_t      dec,
    input rv_pkg::opnd_t     opnd,
    input logic              wb_en,
    input rv_pkg::reg_addr_t wb_rd,
    input rv_pkg::retire_t   retire
);

    int fail_count = 0;

    no_x0_write: assert property (@(posedge aclk) disable iff (!arst_n)
        wb_en |-> (wb_rd != 5'd0))
        else begin
            fail_count++;
            $error("write-back enabled with rd x0");
        end

    // Three stages, so a valid input retires three edges later
    valid_latency: assert property (@(posedge aclk) disable iff (!arst_n)
        in_valid |-> ##3 retire.valid)
        else begin
            fail_count++;
            $error("valid instruction did not retire 3 cycles after input");
        end

    bubble_latency: assert property (@(posedge aclk) disable iff (!arst_n)
        !in_valid |-> ##3 !retire.valid)
        else begin
            fail_count++;
            $error("retire valid without an input 3 cycles earlier");
        end

    reset_clears: assert property (@(posedge aclk)
        !arst_n |-> !(dec.valid || opnd.valid || retire.valid || wb_en))
        else begin
            fail_count++;
            $error("valid bit or write enable high during reset");
        end

endmodule

bind rv_core rv_core_asserts u_asserts (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .dec      (dec),
    .opnd     (opnd),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .retire   (retire)
);

// File: dv/tb_rv_core.sv
// Testbench top with directed then random RV32I stimulus and a watchdog
// Random rd and rs stay in x0..x7 so dependencies are frequent
`timescale 1ns/1ps

module tb_rv_core;

    localparam int N_RANDOM     = 2000;
    localparam int N_DIRECTED   = 60;
    localparam int RESET_CYCLES = 5;
    // A random instruction can be followed by one bubble
    localparam int RUN_CYCLES   = RESET_CYCLES + N_DIRECTED + 2 * N_RANDOM + 50;

    logic            aclk;
    logic            arst_n;
    logic            in_valid;
    rv_pkg::xlen_t   in_pc;
    rv_pkg::instr_t  in_instr;
    rv_pkg::retire_t retire;
    logic [7:0]      test_id;
    logic [7:0]      section;
    logic [31:0]     rng;
    rv_pkg::xlen_t   pc;
    int              error_count;
    int              check_count;
    int              pending;
    int              assert_errors;
    logic [6:0]      report_opc [8] = '{7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h73, 7'h0f, 7'h0f};

    rv_core uut (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .retire   (retire)
    );

    rv_checker u_checker (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_instr    (in_instr),
        .test_id     (test_id),
        .retire      (retire),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    always #5 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rv_pkg::instr_t make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::instr_t make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::instr_t make_u(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic send(input rv_pkg::instr_t instr);
        @(posedge aclk);
        #1;
        in_valid = 1'b1;
        in_pc    = pc;
        in_instr = instr;
        test_id  = section;
        pc       = pc + 32'd4;
    endtask

    task automatic bubble();
        @(posedge aclk);
        #1;
        in_valid = 1'b0;
        in_instr = '0;
        test_id  = section;
    endtask

    task automatic send_random();
        logic [31:0]    r;
        logic [31:0]    s;
        logic [2:0]     f3;
        logic [11:0]    imm;
        logic           alt;
        rv_pkg::instr_t instr;
        rng   = xorshift32(rng);
        r     = rng;
        rng   = xorshift32(rng);
        s     = rng;
        f3    = r[6:4];
        imm   = s[31:20];
        alt   = s[12];
        case (r[3:0])
            4'd6, 4'd7, 4'd8, 4'd9: begin
                instr = make_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                               s[8:6], s[5:3], f3, s[2:0]);
            end
            4'd10: instr = make_u(s[31:12], s[2:0], 7'b0110111);
            4'd11: instr = make_u(s[31:12], s[2:0], 7'b0010111);
            4'd12, 4'd13: instr = {s[31:7], report_opc[r[10:8]]};
            // Low opcode bits never 11, so always outside RV32I
            4'd14: instr = {s[31:7], r[10:6], 1'b0, r[11]};
            default: begin
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = alt ? 7'h20 : 7'h00;
                end
                instr = make_i(imm, s[5:3], f3, s[2:0], 7'b0010011);
            end
        endcase
        send(instr);
        if (r[31:29] == 3'b000) begin
            bubble();
        end
    endtask

    initial begin
        #(RUN_CYCLES * 10);
        $display("Timeout after %0d cycles, the pipeline did not drain", RUN_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        aclk     = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_pc    = '0;
        in_instr = '0;
        test_id  = '0;
        section  = '0;
        rng      = 32'd25;
        pc       = 32'h0000_1000;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        // Reported classes and illegal opcodes
        section = 8'd1;
        send(make_i(12'h123, 5'd1, 3'b000, 5'd2, 7'h6f));
        send(make_i(12'h010, 5'd1, 3'b000, 5'd3, 7'h67));
        send(make_i(12'h7f0, 5'd2, 3'b001, 5'd4, 7'h63));
        send(make_i(12'h004, 5'd1, 3'b010, 5'd5, 7'h03));
        send(make_i(12'h008, 5'd1, 3'b010, 5'd6, 7'h23));
        send(32'h0000_0073);
        send(make_i(12'h300, 5'd1, 3'b001, 5'd7, 7'h73));
        send(32'h0ff0_000f);
        send(32'h0000_100f);
        send(make_i(12'h0ab, 5'd1, 3'b000, 5'd1, 7'h7f));
        send(make_i(12'h0ab, 5'd1, 3'b000, 5'd2, 7'h0b));
        send(32'h0000_0000);

        // x1 = -5 and x2 = 3, then every funct3
        section = 8'd2;
        send(make_i(12'hffb, 5'd0, 3'b000, 5'd1, 7'h13));
        send(make_i(12'h003, 5'd0, 3'b000, 5'd2, 7'h13));
        for (int f = 0; f < 8; f++) begin
            send(make_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3 + f[4:0] % 5));
        end
        send(make_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        send(make_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd5));
        send(make_i(12'hfff, 5'd1, 3'b010, 5'd3, 7'h13));
        send(make_i(12'hfff, 5'd1, 3'b011, 5'd4, 7'h13));
        send(make_i(12'hfff, 5'd1, 3'b100, 5'd5, 7'h13));
        send(make_i(12'h800, 5'd2, 3'b110, 5'd6, 7'h13));
        send(make_i(12'h0f0, 5'd1, 3'b111, 5'd7, 7'h13));
        send(make_i(12'h01f, 5'd1, 3'b001, 5'd3, 7'h13));
        send(make_i(12'h004, 5'd1, 3'b101, 5'd4, 7'h13));
        send(make_i(12'h404, 5'd1, 3'b101, 5'd5, 7'h13));
        send(make_i(12'h800, 5'd1, 3'b000, 5'd6, 7'h13));

        section = 8'd3;
        send(make_u(20'habcde, 5'd1, 7'h37));
        send(make_u(20'h12345, 5'd2, 7'h17));
        send(make_u(20'hfffff, 5'd3, 7'h17));
        send(make_u(20'h80000, 5'd4, 7'h37));

        // Previous, two back, and across a bubble
        section = 8'd4;
        send(make_i(12'h001, 5'd0, 3'b000, 5'd1, 7'h13));
        send(make_i(12'h001, 5'd1, 3'b000, 5'd1, 7'h13));
        send(make_i(12'h001, 5'd1, 3'b000, 5'd1, 7'h13));
        send(make_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        send(make_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
        bubble();
        send(make_r(7'h00, 5'd3, 5'd3, 3'b000, 5'd4));
        send(make_i(12'hfff, 5'd4, 3'b000, 5'd4, 7'h13));
        send(make_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));

        section = 8'd5;
        send(make_i(12'd77, 5'd1, 3'b000, 5'd0, 7'h13));
        send(make_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd3));
        send(make_u(20'h12345, 5'd0, 7'h37));
        send(make_r(7'h00, 5'd1, 5'd0, 3'b110, 5'd4));
        send(make_i(12'h000, 5'd0, 3'b000, 5'd5, 7'h13));

        section = 8'd6;
        repeat (N_RANDOM) send_random();
        bubble();

        while (pending != 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);

        assert_errors = uut.u_asserts.fail_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: src/rv_core.sv
// RV32I pipeline slice top, three stages with a fixed latency of 3 cycles
// No stalls, branches, memory access or traps
`timescale 1ns/1ps

module rv_core (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  rv_pkg::xlen_t   in_pc,
    input  rv_pkg::instr_t  in_instr,
    output rv_pkg::retire_t retire
);

    rv_pkg::dec_t      dec;
    rv_pkg::opnd_t     opnd;
    logic              wb_en;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::xlen_t     wb_data;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;

    rv_decoder u_decoder (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .dec      (dec)
    );

    rv_operand u_operand (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .dec      (dec),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .opnd     (opnd)
    );

    rv_execute u_execute (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .opnd    (opnd),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .retire  (retire)
    );

    rv_regfile u_regfile (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// File: src/rv_decoder.sv
// Decode stage, one cycle. Fields are extracted for every opcode and
// immediates follow the RV32I bit layouts per format
`timescale 1ns/1ps

module rv_decoder (
    input  logic           aclk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  rv_pkg::xlen_t  in_pc,
    input  rv_pkg::instr_t in_instr,
    output rv_pkg::dec_t   dec
);

    rv_pkg::dec_t    dec_d;
    rv_pkg::opcode_t opcode;
    rv_pkg::imm12_t  funct12;

    assign opcode  = in_instr[6:0];
    assign funct12 = in_instr[31:20];

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = in_valid;
        dec_d.pc       = in_pc;
        dec_d.funct3   = in_instr[14:12];
        dec_d.funct7_5 = in_instr[30];
        dec_d.rs1      = in_instr[19:15];
        dec_d.rs2      = in_instr[24:20];
        dec_d.rd       = in_instr[11:7];

        case (opcode)
            rv_pkg::OPC_LUI: begin
                dec_d.iclass = rv_pkg::CL_LUI;
                dec_d.imm20  = in_instr[31:12];
            end
            rv_pkg::OPC_AUIPC: begin
                dec_d.iclass = rv_pkg::CL_AUIPC;
                dec_d.imm20  = in_instr[31:12];
            end
            rv_pkg::OPC_JAL: begin
                dec_d.iclass = rv_pkg::CL_JAL;
                // J-type offset without its implied zero bit
                dec_d.imm20  = {in_instr[31], in_instr[19:12], in_instr[20], in_instr[30:21]};
            end
            rv_pkg::OPC_JALR: begin
                dec_d.iclass = rv_pkg::CL_JALR;
                dec_d.imm12  = in_instr[31:20];
            end
            rv_pkg::OPC_BRANCH: begin
                dec_d.iclass = rv_pkg::CL_BRANCH;
                dec_d.imm12  = {in_instr[31], in_instr[7], in_instr[30:25], in_instr[11:8]};
            end
            rv_pkg::OPC_SYSTEM: begin
                dec_d.iclass = rv_pkg::CL_SYSTEM;
                if (in_instr[14:12] != 3'b000) begin
                    dec_d.sys = rv_pkg::SYS_CSR;
                end else begin
                    // Privileged ops told apart by funct12
                    case (funct12)
                        rv_pkg::F12_ECALL:  dec_d.sys = rv_pkg::SYS_ECALL;
                        rv_pkg::F12_EBREAK: dec_d.sys = rv_pkg::SYS_EBREAK;
                        rv_pkg::F12_MRET:   dec_d.sys = rv_pkg::SYS_MRET;
                        rv_pkg::F12_SRET:   dec_d.sys = rv_pkg::SYS_SRET;
                        default:            dec_d.sys = rv_pkg::SYS_WFI;
                    endcase
                end
            end
            rv_pkg::OPC_FENCE: begin
                dec_d.iclass = rv_pkg::CL_FENCE;
                // funct3 bit 0 marks fence.i
                if (in_instr[12]) begin
                    dec_d.fence = rv_pkg::FENCE_I;
                end else begin
                    dec_d.fence = rv_pkg::FENCE_PLAIN;
                end
            end
            rv_pkg::OPC_LOAD: begin
                dec_d.iclass = rv_pkg::CL_LOAD;
                dec_d.imm12  = in_instr[31:20];
            end
            rv_pkg::OPC_STORE: begin
                dec_d.iclass = rv_pkg::CL_STORE;
                dec_d.imm12  = {in_instr[31:25], in_instr[11:7]};
            end
            rv_pkg::OPC_OPIMM: begin
                dec_d.iclass = rv_pkg::CL_OPIMM;
                dec_d.imm12  = in_instr[31:20];
            end
            rv_pkg::OPC_OP: begin
                dec_d.iclass = rv_pkg::CL_OP;
            end
            default: begin
                dec_d.iclass = rv_pkg::CL_ILLEGAL;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_d;
        end
    end

endmodule

// File: src/rv_execute.sv
// Execute stage with the RV32I ALU, one cycle to the retire register
// Write-back signals are combinational and land with retire at the same edge
`timescale 1ns/1ps

module rv_execute (
    input  logic              aclk,
    input  logic              arst_n,
    input  rv_pkg::opnd_t     opnd,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::xlen_t     wb_data,
    output rv_pkg::retire_t   retire
);

    logic            is_upper;
    logic            executed;
    logic            sub;
    logic [4:0]      shamt;
    rv_pkg::funct3_t alu_op;
    rv_pkg::xlen_t   alu_res;
    rv_pkg::retire_t retire_d;

    assign is_upper = (opnd.iclass == rv_pkg::CL_LUI) || (opnd.iclass == rv_pkg::CL_AUIPC);
    assign executed = is_upper || (opnd.iclass == rv_pkg::CL_OPIMM)
                    || (opnd.iclass == rv_pkg::CL_OP);

    // LUI and AUIPC funct3 bits are immediate bits, force add
    assign alu_op = is_upper ? 3'b000 : opnd.funct3;
    // Sub only in register form
    assign sub    = opnd.funct7_5 && !opnd.b_imm;
    assign shamt  = opnd.b[4:0];

    always_comb begin
        alu_res = '0;
        case (alu_op)
            3'b000: begin
                if (sub) begin
                    alu_res = opnd.a - opnd.b;
                end else begin
                    alu_res = opnd.a + opnd.b;
                end
            end
            3'b001: alu_res = opnd.a << shamt;
            3'b010: alu_res = {31'b0, $signed(opnd.a) < $signed(opnd.b)};
            3'b011: alu_res = {31'b0, opnd.a < opnd.b};
            3'b100: alu_res = opnd.a ^ opnd.b;
            3'b101: begin
                if (opnd.funct7_5) begin
                    alu_res = $signed(opnd.a) >>> shamt;
                end else begin
                    alu_res = opnd.a >> shamt;
                end
            end
            3'b110: alu_res = opnd.a | opnd.b;
            3'b111: alu_res = opnd.a & opnd.b;
            default: alu_res = '0;
        endcase
    end

    assign wb_en   = opnd.valid && executed && (opnd.rd != '0);
    assign wb_rd   = opnd.rd;
    assign wb_data = alu_res;

    always_comb begin
        retire_d         = '0;
        retire_d.valid   = opnd.valid;
        retire_d.pc      = opnd.pc;
        retire_d.iclass  = opnd.iclass;
        retire_d.rd      = opnd.rd;
        retire_d.result  = executed ? alu_res : '0;
        retire_d.wrote   = wb_en;
        retire_d.illegal = (opnd.iclass == rv_pkg::CL_ILLEGAL);
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire <= retire_d;
        end
    end

endmodule

// File: src/rv_operand.sv
// Operand stage, one cycle. Bypass covers only the instruction in execute,
// older results come through the register file
`timescale 1ns/1ps

module rv_operand (
    input  logic              aclk,
    input  logic              arst_n,
    input  rv_pkg::dec_t      dec,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::xlen_t     rs1_data,
    input  rv_pkg::xlen_t     rs2_data,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::xlen_t     wb_data,
    output rv_pkg::opnd_t     opnd
);

    rv_pkg::xlen_t rs1_val;
    rv_pkg::xlen_t rs2_val;
    rv_pkg::xlen_t imm_u;
    rv_pkg::xlen_t imm_i;
    rv_pkg::opnd_t opnd_d;

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    // wb_en is never set for x0, so no zero check here
    assign rs1_val = (wb_en && (wb_rd == dec.rs1)) ? wb_data : rs1_data;
    assign rs2_val = (wb_en && (wb_rd == dec.rs2)) ? wb_data : rs2_data;

    assign imm_u = {dec.imm20, 12'b0};
    assign imm_i = {{20{dec.imm12[11]}}, dec.imm12};

    always_comb begin
        opnd_d          = '0;
        opnd_d.valid    = dec.valid;
        opnd_d.pc       = dec.pc;
        opnd_d.iclass   = dec.iclass;
        opnd_d.funct3   = dec.funct3;
        opnd_d.funct7_5 = dec.funct7_5;
        opnd_d.rd       = dec.rd;

        case (dec.iclass)
            rv_pkg::CL_LUI: begin
                opnd_d.b     = imm_u;
                opnd_d.b_imm = 1'b1;
            end
            rv_pkg::CL_AUIPC: begin
                opnd_d.a     = dec.pc;
                opnd_d.b     = imm_u;
                opnd_d.b_imm = 1'b1;
            end
            rv_pkg::CL_OPIMM: begin
                opnd_d.a     = rs1_val;
                opnd_d.b     = imm_i;
                opnd_d.b_imm = 1'b1;
            end
            rv_pkg::CL_OP: begin
                opnd_d.a = rs1_val;
                opnd_d.b = rs2_val;
            end
            default: begin
                opnd_d.b_imm = 1'b0;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            opnd <= '0;
        end else begin
            opnd <= opnd_d;
        end
    end

endmodule

// File: src/rv_pkg.sv
// Widths, opcodes, class codes and stage structs shared by the RV32I pipeline slice
// XLEN is fixed at 32 and the class code values are local to this design
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [3:0]      iclass_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [11:0]     imm12_t;
    typedef logic [19:0]     imm20_t;
    typedef logic [5:0]      sys_t;
    typedef logic [1:0]      fence_t;

    // Base opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;

    // Executed classes first
    localparam iclass_t CL_LUI     = 4'd0;
    localparam iclass_t CL_AUIPC   = 4'd1;
    localparam iclass_t CL_OPIMM   = 4'd2;
    localparam iclass_t CL_OP      = 4'd3;
    localparam iclass_t CL_JAL     = 4'd4;
    localparam iclass_t CL_JALR    = 4'd5;
    localparam iclass_t CL_BRANCH  = 4'd6;
    localparam iclass_t CL_LOAD    = 4'd7;
    localparam iclass_t CL_STORE   = 4'd8;
    localparam iclass_t CL_SYSTEM  = 4'd9;
    localparam iclass_t CL_FENCE   = 4'd10;
    localparam iclass_t CL_ILLEGAL = 4'd15;

    // System subcode, one hot
    localparam sys_t SYS_ECALL  = 6'b000001;
    localparam sys_t SYS_EBREAK = 6'b000010;
    localparam sys_t SYS_CSR    = 6'b000100;
    localparam sys_t SYS_MRET   = 6'b001000;
    localparam sys_t SYS_SRET   = 6'b010000;
    localparam sys_t SYS_WFI    = 6'b100000;

    localparam imm12_t F12_ECALL  = 12'h000;
    localparam imm12_t F12_EBREAK = 12'h001;
    localparam imm12_t F12_SRET   = 12'h102;
    localparam imm12_t F12_MRET   = 12'h302;

    localparam fence_t FENCE_PLAIN = 2'b01;
    localparam fence_t FENCE_I     = 2'b10;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        iclass_t   iclass;
        funct3_t   funct3;
        logic      funct7_5;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        imm12_t    imm12;
        imm20_t    imm20;
        sys_t      sys;
        fence_t    fence;
    } dec_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        iclass_t   iclass;
        funct3_t   funct3;
        logic      funct7_5;
        reg_addr_t rd;
        xlen_t     a;
        xlen_t     b;
        logic      b_imm;
    } opnd_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        iclass_t   iclass;
        reg_addr_t rd;
        xlen_t     result;
        logic      wrote;
        logic      illegal;
    } retire_t;

endpackage

// File: src/rv_regfile.sv
// 32 x 32 register file, asynchronous reads, one write port
// Entry zero has no storage and reads as zero
`timescale 1ns/1ps

module rv_regfile (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::xlen_t     wb_data,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data
);

    rv_pkg::xlen_t regs [1:31];

    for (genvar i = 1; i < 32; i++) begin : g_reg
        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                regs[i] <= '0;
            end else if (wb_en && (wb_rd == i[4:0])) begin
                regs[i] <= wb_data;
            end
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: tb.f
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_operand.sv
src/rv_execute.sv
src/rv_core.sv
dv/rv_core_asserts.sv
dv/rv_checker.sv
dv/tb_rv_core.sv
